/* files.f */
hw/roce_eval_pkg.sv
hw/send_queue_fifo.sv
hw/run_control.sv
hw/tx_tracker.sv
hw/ack_checker.sv
hw/latency_accumulator.sv
hw/roce_perf_eval.sv
testbench/tb_roce_perf_eval.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -j 0 --top-module tb_roce_perf_eval -f files.f &&
  ./obj_dir/Vtb_roce_perf_eval | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

/* testbench/tb_roce_perf_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_roce_perf_eval import roce_eval_pkg::*; ();

  // Cycles allowed for run_done to follow the last ACK
  localparam int DONE_TIMEOUT = 50;

  logic      clk;
  logic      rst;
  logic      start;
  count_t    n_transfers;
  logic      tx_bth_valid;
  opcode_t   tx_bth_op_code;
  psn_t      tx_bth_psn;
  logic      rx_bth_valid;
  logic      rx_aeth_valid;
  opcode_t   rx_bth_op_code;
  psn_t      rx_bth_psn;
  syndrome_t rx_aeth_syndrome;
  stamp_t    transfer_time;
  stamp_t    transfer_time_no_ack;
  stamp_t    latency_total;
  count_t    acked_messages;
  logic      bad_transfer;
  logic      run_done;

  int errors = 0;
  int checks = 0;

  // Own cycle count, latencies are differences of it
  logic [63:0] cyc = '0;

  // Reference model: outstanding packets in send order
  psn_t        ref_psn[$];
  logic [63:0] ref_tx[$];
  logic        ref_first[$];
  logic        ref_last[$];
  // Expected outputs
  logic [63:0] exp_latency;
  logic [63:0] exp_tt;
  logic [63:0] exp_tt_no_ack;
  logic [63:0] exp_msgs;
  logic [63:0] msg_start;
  logic        exp_bad;

  roce_perf_eval #(
    .QUEUE_DEPTH(16)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 64'd1;
  end

  // Results stay frozen once a transfer went bad
  a_frozen_totals: assert property (@(posedge clk) disable iff (rst)
    ($past(bad_transfer) && bad_transfer) |-> ($stable(latency_total) &&
    $stable(acked_messages) && $stable(transfer_time) &&
    $stable(transfer_time_no_ack)))
    else begin
      errors++;
      $display("Totals changed while bad_transfer was set");
    end

  // Model count runs ahead of the DUT, so done needs the model at target
  a_done_needs_count: assert property (@(posedge clk) disable iff (rst)
    run_done |-> (exp_msgs == 64'(n_transfers) && n_transfers != '0))
    else begin
      errors++;
      $display("run_done high before the requested messages were acknowledged");
    end

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("ERR %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  task automatic clear_model();
    ref_psn.delete();
    ref_tx.delete();
    ref_first.delete();
    ref_last.delete();
    exp_latency   = '0;
    exp_tt        = '0;
    exp_tt_no_ack = '0;
    exp_msgs      = '0;
    msg_start     = '0;
    exp_bad       = 1'b0;
  endtask

  // One transmitted BTH, recorded with its send cycle
  task automatic send_packet(input opcode_t op, output psn_t psn);
    logic first;
    logic last;
    psn   = psn_t'($urandom);
    first = (op == RC_RDMA_WRITE_FIRST) || (op == RC_RDMA_WRITE_ONLY) ||
            (op == RC_RDMA_WRITE_ONLY_IMD);
    last  = (op == RC_RDMA_WRITE_LAST) || (op == RC_RDMA_WRITE_LAST_IMD) ||
            (op == RC_RDMA_WRITE_ONLY) || (op == RC_RDMA_WRITE_ONLY_IMD);
    tx_bth_valid   = 1'b1;
    tx_bth_op_code = op;
    tx_bth_psn     = psn;
    ref_psn.push_back(psn);
    ref_tx.push_back(cyc);
    ref_first.push_back(first);
    ref_last.push_back(last);
    @(negedge clk);
    tx_bth_valid = 1'b0;
  endtask

  // ACK header with AETH, reference updated from the same cycle
  task automatic receive_ack(input psn_t psn, input syndrome_t syndrome);
    logic [63:0] tx;
    rx_bth_valid     = 1'b1;
    rx_aeth_valid    = 1'b1;
    rx_bth_op_code   = RC_RDMA_ACK;
    rx_bth_psn       = psn;
    rx_aeth_syndrome = syndrome;
    if (!exp_bad) begin
      if (ref_psn.size() == 0 || ref_psn[0] != psn || syndrome[6:5] != 2'b00) begin
        exp_bad = 1'b1;
      end else begin
        tx = ref_tx[0];
        exp_latency = exp_latency + (cyc - tx);
        if (ref_first[0]) begin
          msg_start = tx;
        end
        // Message closed by this packet
        if (ref_last[0]) begin
          exp_tt        = cyc - msg_start;
          exp_tt_no_ack = tx - msg_start;
          exp_msgs      = exp_msgs + 64'd1;
        end
        ref_psn.delete(0);
        ref_tx.delete(0);
        ref_first.delete(0);
        ref_last.delete(0);
      end
    end
    @(negedge clk);
    rx_bth_valid  = 1'b0;
    rx_aeth_valid = 1'b0;
  endtask

  // Headers to be dropped: a write with AETH, then an ACK without AETH
  task automatic receive_other();
    rx_bth_valid     = 1'b1;
    rx_aeth_valid    = 1'b1;
    rx_bth_op_code   = RC_RDMA_WRITE_MIDDLE;
    rx_bth_psn       = psn_t'($urandom);
    rx_aeth_syndrome = 8'h00;
    @(negedge clk);
    rx_aeth_valid  = 1'b0;
    rx_bth_op_code = RC_RDMA_ACK;
    rx_bth_psn     = psn_t'($urandom);
    @(negedge clk);
    rx_bth_valid = 1'b0;
  endtask

  task automatic restart_run();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    // Clear pulse, then cleared state
    idle(2);
    clear_model();
  endtask

  task automatic check_results(input string scen);
    expect_equal({scen, " latency_total"}, exp_latency, latency_total);
    expect_equal({scen, " transfer_time"}, exp_tt, transfer_time);
    expect_equal({scen, " transfer_time_no_ack"}, exp_tt_no_ack, transfer_time_no_ack);
    expect_equal({scen, " acked_messages"}, exp_msgs, 64'(acked_messages));
    expect_equal({scen, " bad_transfer"}, 64'(exp_bad), 64'(bad_transfer));
  endtask

  initial begin
    psn_t p0;
    psn_t p1;
    psn_t p2;
    int   waited;
    void'($urandom(34));
    rst              = 1'b1;
    start            = 1'b0;
    n_transfers      = '0;
    tx_bth_valid     = 1'b0;
    tx_bth_op_code   = '0;
    tx_bth_psn       = '0;
    rx_bth_valid     = 1'b0;
    rx_aeth_valid    = 1'b0;
    rx_bth_op_code   = '0;
    rx_bth_psn       = '0;
    rx_aeth_syndrome = '0;
    clear_model();
    idle(8);
    rst = 1'b0;
    idle(2);

    // Single packet, unrelated headers before its ACK
    send_packet(RC_RDMA_WRITE_ONLY, p0);
    idle(1 + int'($urandom % 5));
    receive_other();
    idle(int'($urandom % 5));
    receive_ack(p0, 8'h00);
    idle(2);
    check_results("single_only");

    // Three-packet message, ACKs in order
    send_packet(RC_RDMA_WRITE_FIRST, p0);
    idle(int'($urandom % 4));
    send_packet(RC_RDMA_WRITE_MIDDLE, p1);
    idle(int'($urandom % 4));
    send_packet(RC_RDMA_WRITE_LAST, p2);
    idle(1 + int'($urandom % 4));
    receive_ack(p0, 8'h00);
    idle(int'($urandom % 4));
    receive_ack(p1, 8'h00);
    receive_ack(p2, 8'h00);
    idle(2);
    check_results("multi_packet");

    // NAK code in bits 6:5, later good ACK ignored
    send_packet(RC_RDMA_WRITE_ONLY, p0);
    idle(3);
    receive_ack(p0, 8'h60);
    idle(2);
    check_results("nak_freezes");
    receive_ack(p0, 8'h00);
    idle(2);
    check_results("nak_freezes");

    restart_run();
    check_results("restart_clears");

    // ACK for a PSN that is not the oldest
    send_packet(RC_RDMA_WRITE_ONLY, p0);
    send_packet(RC_RDMA_WRITE_ONLY, p1);
    idle(2);
    receive_ack(p0 ^ psn_t'(1), 8'h00);
    idle(2);
    check_results("psn_mismatch");

    // Fresh message after restart
    restart_run();
    check_results("restart_clears");
    send_packet(RC_RDMA_WRITE_FIRST, p0);
    idle(2);
    send_packet(RC_RDMA_WRITE_LAST_IMD, p1);
    idle(3);
    receive_ack(p0, 8'h00);
    receive_ack(p1, 8'h00);
    idle(2);
    check_results("restart_clears");

    // Three messages against a target of three
    restart_run();
    n_transfers = 32'd3;
    send_packet(RC_RDMA_WRITE_ONLY_IMD, p0);
    idle(2);
    receive_ack(p0, 8'h00);
    send_packet(RC_RDMA_WRITE_FIRST, p1);
    send_packet(RC_RDMA_WRITE_LAST_IMD, p2);
    idle(2);
    receive_ack(p1, 8'h00);
    receive_ack(p2, 8'h00);
    idle(2);
    expect_equal("run_done after two", 64'd0, 64'(run_done));
    send_packet(RC_RDMA_WRITE_ONLY, p0);
    idle(4);
    receive_ack(p0, 8'h00);
    expect_equal("run_done in event cycle", 64'd0, 64'(run_done));
    waited = 0;
    while (!run_done && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!run_done) begin
      errors++;
      $display("Timeout: run_done did not rise after the third message");
    end else begin
      expect_equal("run_done delay", 64'd1, 64'(waited));
    end
    check_results("run_done");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/roce_perf_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module roce_perf_eval import roce_eval_pkg::*; #(
  parameter int QUEUE_DEPTH = SEND_QUEUE_DEPTH_DEFAULT
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  count_t    n_transfers,
  // Transmit side BTH
  input  logic      tx_bth_valid,
  input  opcode_t   tx_bth_op_code,
  input  psn_t      tx_bth_psn,
  // Receive side BTH and AETH
  input  logic      rx_bth_valid,
  input  logic      rx_aeth_valid,
  input  opcode_t   rx_bth_op_code,
  input  psn_t      rx_bth_psn,
  input  syndrome_t rx_aeth_syndrome,
  // Results
  output stamp_t    transfer_time,
  output stamp_t    transfer_time_no_ack,
  output stamp_t    latency_total,
  output count_t    acked_messages,
  output logic      bad_transfer,
  output logic      run_done
);

  logic   clear;
  stamp_t now;

  send_queue_if sq ();
  ack_event_if  ev ();

  // Start edge and time base
  run_control u_run_control (
    .clk  (clk),
    .rst  (rst),
    .start(start),
    .clear(clear),
    .now  (now)
  );

  // Outstanding packets with their send times
  tx_tracker #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_tx_tracker (
    .clk           (clk),
    .rst           (rst),
    .clear         (clear),
    .now           (now),
    .tx_bth_valid  (tx_bth_valid),
    .tx_bth_op_code(tx_bth_op_code),
    .tx_bth_psn    (tx_bth_psn),
    .sq            (sq)
  );

  ack_checker u_ack_checker (
    .clk             (clk),
    .rst             (rst),
    .clear           (clear),
    .now             (now),
    .rx_bth_valid    (rx_bth_valid),
    .rx_aeth_valid   (rx_aeth_valid),
    .rx_bth_op_code  (rx_bth_op_code),
    .rx_bth_psn      (rx_bth_psn),
    .rx_aeth_syndrome(rx_aeth_syndrome),
    .ev              (ev)
  );

  latency_accumulator u_latency_accumulator (
    .clk                 (clk),
    .rst                 (rst),
    .clear               (clear),
    .n_transfers         (n_transfers),
    .sq                  (sq),
    .ev                  (ev),
    .transfer_time       (transfer_time),
    .transfer_time_no_ack(transfer_time_no_ack),
    .latency_total       (latency_total),
    .acked_messages      (acked_messages),
    .bad_transfer        (bad_transfer),
    .run_done            (run_done)
  );

endmodule

`default_nettype wire

/* hw/latency_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module latency_accumulator import roce_eval_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  logic           clear,
  input  count_t         n_transfers,
  send_queue_if.consumer sq,
  ack_event_if.sink      ev,
  output stamp_t         transfer_time,
  output stamp_t         transfer_time_no_ack,
  output stamp_t         latency_total,
  output count_t         acked_messages,
  output logic           bad_transfer,
  output logic           run_done
);

  logic   match;
  stamp_t msg_start;
  stamp_t start_sel;
  stamp_t rtt;

  // Positive ACK for the oldest outstanding PSN
  assign match = ev.valid && !bad_transfer && sq.head_valid &&
                 (sq.head_entry.psn == ev.psn) && ev.ok;

  // Pop in the event cycle itself
  assign sq.pop = match;

  // Round trip of the head packet
  assign rtt = ev.stamp - sq.head_stamp;

  // Single-packet message starts at its own send time
  assign start_sel = sq.head_entry.first ? sq.head_stamp : msg_start;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      transfer_time        <= '0;
      transfer_time_no_ack <= '0;
      latency_total        <= '0;
      acked_messages       <= '0;
      bad_transfer         <= 1'b0;
    end else begin
      if (match) begin
        latency_total <= latency_total + rtt;
        // Message closed by this ACK
        if (sq.head_entry.last) begin
          transfer_time        <= ev.stamp - start_sel;
          transfer_time_no_ack <= sq.head_stamp - start_sel;
          acked_messages       <= acked_messages + count_t'(1);
        end
      end else if (ev.valid) begin
        // NAK, wrong PSN or nothing outstanding
        bad_transfer <= 1'b1;
      end
    end
  end

  // First send time of the open message
  always_ff @(posedge clk) begin
    if (match && sq.head_entry.first) begin
      msg_start <= sq.head_stamp;
    end
  end

  // Level, follows the count
  assign run_done = (acked_messages == n_transfers) && (acked_messages != '0);

  // Sticky error only drops on a run restart
  a_bad_sticky: assert property (@(posedge clk) disable iff (rst)
    $fell(bad_transfer) |-> $past(clear));

endmodule

`default_nettype wire

/* hw/ack_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// One registered acknowledgement per valid strobe
interface ack_event_if import roce_eval_pkg::*; ();
  logic   valid;
  psn_t   psn;
  logic   ok;
  stamp_t stamp;

  modport source (output valid, output psn, output ok, output stamp);
  modport sink (input valid, input psn, input ok, input stamp);
endinterface

module ack_checker import roce_eval_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       clear,
  input  stamp_t     now,
  input  logic       rx_bth_valid,
  input  logic       rx_aeth_valid,
  input  opcode_t    rx_bth_op_code,
  input  psn_t       rx_bth_psn,
  input  syndrome_t  rx_aeth_syndrome,
  ack_event_if.source ev
);

  logic is_ack;

  // Only ACK headers that carry an AETH
  assign is_ack = rx_bth_valid && rx_aeth_valid && (rx_bth_op_code == RC_RDMA_ACK);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      ev.valid <= 1'b0;
    end else begin
      ev.valid <= is_ack;
    end
  end

  // Event payload, held until the next ACK
  always_ff @(posedge clk) begin
    if (is_ack) begin
      ev.psn   <= rx_bth_psn;
      // Receive cycle time, not the event cycle
      ev.stamp <= now;
      ev.ok    <= (rx_aeth_syndrome[AETH_CODE_HI:AETH_CODE_LO] == AETH_CODE_ACK);
    end
  end

endmodule

`default_nettype wire

/* hw/tx_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

// Head of the outstanding packet queue
interface send_queue_if import roce_eval_pkg::*; ();
  logic        head_valid;
  stamp_t      head_stamp;
  send_entry_t head_entry;
  // Only while head_valid, head advances on the next edge
  logic        pop;

  modport producer (output head_valid, output head_stamp, output head_entry, input pop);
  modport consumer (input head_valid, input head_stamp, input head_entry, output pop);
endinterface

module tx_tracker import roce_eval_pkg::*; #(
  parameter int QUEUE_DEPTH = SEND_QUEUE_DEPTH_DEFAULT
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          clear,
  input  stamp_t        now,
  input  logic          tx_bth_valid,
  input  opcode_t       tx_bth_op_code,
  input  psn_t          tx_bth_psn,
  send_queue_if.producer sq
);

  logic        is_first;
  logic        is_last;
  send_entry_t tx_entry;
  logic        stamp_valid;
  logic        entry_valid;

  // Message boundary flags from the opcode
  always_comb begin
    is_first = 1'b0;
    is_last  = 1'b0;
    case (tx_bth_op_code)
      RC_RDMA_WRITE_FIRST: is_first = 1'b1;
      // Middle packets carry no flag
      RC_RDMA_WRITE_MIDDLE: is_first = 1'b0;
      RC_RDMA_WRITE_LAST, RC_RDMA_WRITE_LAST_IMD: is_last = 1'b1;
      RC_RDMA_WRITE_ONLY, RC_RDMA_WRITE_ONLY_IMD: begin
        is_first = 1'b1;
        is_last  = 1'b1;
      end
      default: is_first = 1'b0;
    endcase
  end

  assign tx_entry.psn   = tx_bth_psn;
  assign tx_entry.first = is_first;
  assign tx_entry.last  = is_last;

  // Send time of each packet
  send_queue_fifo #(
    .DEPTH    (QUEUE_DEPTH),
    .payload_t(stamp_t)
  ) u_stamp_fifo (
    .clk  (clk),
    .rst  (rst),
    .clear(clear),
    .push (tx_bth_valid),
    .din  (now),
    .pop  (sq.pop),
    .dout (sq.head_stamp),
    .valid(stamp_valid)
  );

  // PSN and boundary flags, same push and pop as the stamps
  send_queue_fifo #(
    .DEPTH    (QUEUE_DEPTH),
    .payload_t(send_entry_t)
  ) u_entry_fifo (
    .clk  (clk),
    .rst  (rst),
    .clear(clear),
    .push (tx_bth_valid),
    .din  (tx_entry),
    .pop  (sq.pop),
    .dout (sq.head_entry),
    .valid(entry_valid)
  );

  assign sq.head_valid = stamp_valid;

  // Both queues must hold the same packets
  a_heads_aligned: assert property (@(posedge clk) disable iff (rst)
    stamp_valid == entry_valid);

endmodule

`default_nettype wire

/* hw/run_control.sv */
`timescale 1ns/1ps
`default_nettype none

module run_control import roce_eval_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  output logic   clear,
  output stamp_t now
);

  logic start_d;
  logic start_rise;

  // Rising edge of the start level
  assign start_rise = start && !start_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      start_d <= 1'b0;
      clear   <= 1'b0;
      now     <= '0;
    end else begin
      start_d <= start;
      // One-cycle clear pulse after the edge
      clear   <= start_rise;
      // Counter restarts together with clear
      if (start_rise) begin
        now <= '0;
      end else begin
        now <= now + stamp_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/send_queue_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module send_queue_fifo #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [63:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     clear,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     valid
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset needed
  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  // Pointer advance with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full  = (count == CNT_W'(DEPTH));
  assign valid = (count != '0);
  // Head is read straight from storage
  assign dout  = mem[rd_ptr];

  // Overflowing pushes are dropped
  assign wr_en = push && !full;
  assign rd_en = pop && valid;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Fill level only moves when one side acts alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // No back-pressure exists, so the sender must never overrun the queue
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full));
  // Consumer only pops an entry it has seen
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && !valid));

endmodule

`default_nettype wire

/* hw/roce_eval_pkg.sv */
`default_nettype none

package roce_eval_pkg;

  // Run counter value, every timestamp is taken from it
  typedef logic [63:0] stamp_t;

  // BTH fields
  typedef logic [23:0] psn_t;
  typedef logic [7:0]  opcode_t;

  // Message count and transfer target
  typedef logic [31:0] count_t;

  // AETH syndrome byte
  typedef logic [7:0]  syndrome_t;

  // Syndrome bits 6:5 hold the ACK/NAK code
  localparam int AETH_CODE_HI = 6;
  localparam int AETH_CODE_LO = 5;
  // Code 00 is a positive acknowledgement
  localparam logic [1:0] AETH_CODE_ACK = 2'b00;

  // One outstanding packet in the send queue
  typedef struct packed {
    psn_t psn;
    // Opens a write message
    logic first;
    // Closes a write message
    logic last;
  } send_entry_t;

  // RC opcodes of interest
  localparam opcode_t RC_RDMA_WRITE_FIRST    = 8'h06;
  localparam opcode_t RC_RDMA_WRITE_MIDDLE   = 8'h07;
  localparam opcode_t RC_RDMA_WRITE_LAST     = 8'h08;
  localparam opcode_t RC_RDMA_WRITE_LAST_IMD = 8'h09;
  localparam opcode_t RC_RDMA_WRITE_ONLY     = 8'h0A;
  localparam opcode_t RC_RDMA_WRITE_ONLY_IMD = 8'h0B;
  localparam opcode_t RC_RDMA_ACK            = 8'h11;

  // Outstanding packets the send queue can hold
  localparam int SEND_QUEUE_DEPTH_DEFAULT = 1024;

endpackage

`default_nettype wire
